//--- cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

`define DWIDTH    16    // pixel width.
`define WWIDTH    8     // weight width.
`define AWIDTH    40    // accumulator width.
`define LWIDTH    10    // size and counter width.

`define MAXLINE   5     // largest filter side.
`define MAXSIZE   32    // largest image side and line RAM depth.

`define AXI_AW    8

// register map in bytes.
`define REG_CTRL  'h00
`define REG_IMG   'h04
`define REG_FIL   'h08
`define REG_STAT  'h0C
`define REG_WBASE 'h40  // weight r*MAXLINE+c sits at REG_WBASE + 4*(r*MAXLINE+c).

`endif

//--- cnn_pkg.sv
`default_nettype none

`include "cnn_defines.svh"

package cnn_pkg;

  typedef logic signed [`DWIDTH-1:0] pixel_t;
  typedef logic signed [`WWIDTH-1:0] weight_t;
  typedef logic signed [`AWIDTH-1:0] acc_t;

  // element r*MAXLINE + c holds row r and column c.
  typedef pixel_t  [`MAXLINE*`MAXLINE-1:0] window_t;
  typedef weight_t [`MAXLINE*`MAXLINE-1:0] weights_t;

  typedef struct packed {
    logic [`LWIDTH-1:0] img_size;
    logic [`LWIDTH-1:0] fil_size;
  } conv_cfg_t;

  typedef struct packed {
    logic              awvalid;
    logic [`AXI_AW-1:0] awaddr;
    logic              wvalid;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              bready;
    logic              arvalid;
    logic [`AXI_AW-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- conv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module conv_core
  import cnn_pkg::*;
(
  input  wire                clk,
  input  wire                xrst,
  input  wire window_t       win,
  input  wire                win_valid,
  input  wire weights_t      weights,
  input  wire [`LWIDTH-1:0]  fil_size,
  output acc_t               res,
  output logic               res_valid
);

  localparam int NTAP   = `MAXLINE * `MAXLINE;
  localparam int PWIDTH = `DWIDTH + `WWIDTH;

  logic signed [PWIDTH-1:0] prod_q [NTAP];
  logic [1:0]               vld_q;

  // stage 1 forms every product and drops taps outside the filter.
  for (genvar i = 0; i < NTAP; i++) begin : g_tap
    localparam int ROW = i / `MAXLINE;
    localparam int COL = i % `MAXLINE;

    always_ff @(posedge clk) begin
      if (ROW < fil_size && COL < fil_size) begin
        prod_q[i] <= win[i] * weights[i];
      end else begin
        prod_q[i] <= '0;
      end
    end
  end

  // stage 2 adds all products.
  always_ff @(posedge clk) begin
    acc_t sum;
    sum = '0;
    for (int i = 0; i < NTAP; i++) begin
      sum = sum + prod_q[i];
    end
    res <= sum;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      vld_q <= 2'b00;
    end else begin
      vld_q <= {vld_q[0], win_valid};
    end
  end

  assign res_valid = vld_q[1];

endmodule

`default_nettype wire

//--- conv_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module conv_regs
  import cnn_pkg::*;
(
  input  wire            clk,
  input  wire            xrst,
  input  wire axil_req_t axi_req,
  output axil_rsp_t      axi_rsp,
  input  wire            frame_done,
  output conv_cfg_t      cfg,
  output weights_t       weights,
  output logic           start
);

  localparam int          NW          = `MAXLINE * `MAXLINE;
  localparam logic [1:0]  RESP_OKAY   = 2'b00;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;

  conv_cfg_t          cfg_q;
  weights_t           w_q;
  logic               busy;
  logic               done;
  logic               bvalid;
  logic               rvalid;
  logic [1:0]         bresp;
  logic [1:0]         rresp;
  logic [31:0]        rdata;
  logic               wr_fire;
  logic               rd_fire;
  logic               wr_ok;
  logic               rd_ok;
  logic               start_cond;
  logic [31:0]        wr_cur;
  logic [31:0]        wr_merge;
  logic [31:0]        rd_val;
  logic [`AXI_AW-1:0] wr_off;

  // returns 1 for a mapped address and gives the register contents in val.
  function automatic logic reg_lookup(input logic [`AXI_AW-1:0] addr, output logic [31:0] val);
    logic               hit;
    logic [`AXI_AW-1:0] off;
    weight_t            w;
    hit = 1'b1;
    val = '0;
    off = addr - `AXI_AW'(`REG_WBASE);
    w   = w_q[off[`AXI_AW-1:2]];
    if (addr[1:0] != 2'b00) begin
      hit = 1'b0;
    end else if (addr == `AXI_AW'(`REG_CTRL)) begin
      val = '0;
    end else if (addr == `AXI_AW'(`REG_IMG)) begin
      val = 32'(cfg_q.img_size);
    end else if (addr == `AXI_AW'(`REG_FIL)) begin
      val = 32'(cfg_q.fil_size);
    end else if (addr == `AXI_AW'(`REG_STAT)) begin
      val = {30'd0, done, busy};
    end else if (addr >= `AXI_AW'(`REG_WBASE) && off[`AXI_AW-1:2] < NW) begin
      val = {{(32-`WWIDTH){w[`WWIDTH-1]}}, w};  // weights read back sign-extended.
    end else begin
      hit = 1'b0;
    end
    return hit;
  endfunction

  function automatic logic [31:0] strb_merge(input logic [31:0] old, input logic [31:0] din,
                                             input logic [3:0] strb);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? din[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  always_comb begin
    wr_fire    = axi_req.awvalid && axi_req.wvalid && !bvalid;
    rd_fire    = axi_req.arvalid && !rvalid;
    wr_ok      = reg_lookup(axi_req.awaddr, wr_cur);
    rd_ok      = reg_lookup(axi_req.araddr, rd_val);
    wr_merge   = strb_merge(wr_cur, axi_req.wdata, axi_req.wstrb);
    wr_off     = axi_req.awaddr - `AXI_AW'(`REG_WBASE);
    start_cond = wr_fire && (axi_req.awaddr == `AXI_AW'(`REG_CTRL)) && wr_merge[0]
                 && !busy && !start;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      start  <= 1'b0;
      busy   <= 1'b0;
      done   <= 1'b0;
      cfg_q  <= '0;
      w_q    <= '0;
    end else begin
      start <= start_cond;
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (frame_done) begin
        busy <= 1'b0;
        done <= 1'b1;  // sticky until the next start.
      end

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (axi_req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (axi_req.rready) begin
        rvalid <= 1'b0;
      end

      if (wr_fire && wr_ok) begin
        if (axi_req.awaddr == `AXI_AW'(`REG_IMG)) begin
          cfg_q.img_size <= wr_merge[`LWIDTH-1:0];
        end else if (axi_req.awaddr == `AXI_AW'(`REG_FIL)) begin
          cfg_q.fil_size <= wr_merge[`LWIDTH-1:0];
        end else if (axi_req.awaddr >= `AXI_AW'(`REG_WBASE)) begin
          w_q[wr_off[`AXI_AW-1:2]] <= wr_merge[`WWIDTH-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rdata <= rd_val;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    axi_rsp.awready = wr_fire;
    axi_rsp.wready  = wr_fire;
    axi_rsp.bvalid  = bvalid;
    axi_rsp.bresp   = bresp;
    axi_rsp.arready = rd_fire;
    axi_rsp.rvalid  = rvalid;
    axi_rsp.rdata   = rdata;
    axi_rsp.rresp   = rresp;
  end

  assign cfg     = cfg_q;
  assign weights = w_q;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !axi_req.bready |=> bvalid);

  a_start_idle: assert property (@(posedge clk) disable iff (!xrst) start |-> !busy);

endmodule

`default_nettype wire

//--- conv_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module conv_top
  import cnn_pkg::*;
(
  input  wire            clk,
  input  wire            xrst,
  input  wire axil_req_t axi_req,
  output axil_rsp_t      axi_rsp,
  input  wire pixel_t    pix_in,
  output logic           pix_req,
  output acc_t           res,
  output logic           res_valid
);

  conv_cfg_t            cfg;
  weights_t             weights;
  window_t              win;
  logic                 win_valid;
  logic                 start;
  logic                 frame_done;
  logic [`LWIDTH-1:0]   out_side;
  logic [2*`LWIDTH-1:0] res_total;
  logic [2*`LWIDTH-1:0] res_cnt;

  conv_regs u_regs (
    .clk       (clk),
    .xrst      (xrst),
    .axi_req   (axi_req),
    .axi_rsp   (axi_rsp),
    .frame_done(frame_done),
    .cfg       (cfg),
    .weights   (weights),
    .start     (start)
  );

  linebuf u_linebuf (
    .clk      (clk),
    .xrst     (xrst),
    .start    (start),
    .cfg      (cfg),
    .pix_in   (pix_in),
    .pix_req  (pix_req),
    .win      (win),
    .win_valid(win_valid)
  );

  conv_core u_core (
    .clk      (clk),
    .xrst     (xrst),
    .win      (win),
    .win_valid(win_valid),
    .weights  (weights),
    .fil_size (cfg.fil_size),
    .res      (res),
    .res_valid(res_valid)
  );

  // a frame yields (img_size - fil_size + 1)^2 results.
  assign out_side   = cfg.img_size - cfg.fil_size + `LWIDTH'(1);
  assign res_total  = out_side * out_side;
  assign frame_done = res_valid && (res_cnt == res_total - 1'b1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      res_cnt <= '0;
    end else if (start || frame_done) begin
      res_cnt <= '0;
    end else if (res_valid) begin
      res_cnt <= res_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- linebuf.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module linebuf
  import cnn_pkg::*;
(
  input  wire            clk,
  input  wire            xrst,
  input  wire            start,
  input  wire conv_cfg_t cfg,
  input  wire pixel_t    pix_in,
  output logic           pix_req,
  output window_t        win,
  output logic           win_valid
);

  localparam int NRAM      = `MAXLINE + 1;
  localparam int SEL_BITS  = $clog2(NRAM);
  localparam int ADDR_BITS = $clog2(`MAXSIZE);

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  state_t              state;
  logic [`LWIDTH-1:0]  x_cnt;
  logic [`LWIDTH-1:0]  y_cnt;
  logic [SEL_BITS-1:0] ws_cnt;
  logic                line_end;

  logic                a_v;
  pixel_t              a_pix;
  logic [`LWIDTH-1:0]  a_x;
  logic [SEL_BITS-1:0] a_ws;

  logic                b_v;
  pixel_t              b_pix;
  logic [`LWIDTH-1:0]  b_x;
  logic [`LWIDTH-1:0]  b_y;
  logic [SEL_BITS-1:0] b_ws;
  logic [`LWIDTH-1:0]  a_y;

  logic [NRAM-1:0]      ram_we;
  logic [ADDR_BITS-1:0] ram_addr;
  pixel_t               ram_rd [NRAM];
  pixel_t               col_pix [`MAXLINE];
  pixel_t               win_q [`MAXLINE*`MAXLINE];

  assign pix_req  = (state != S_WAIT);
  assign line_end = (x_cnt == cfg.img_size - 1'b1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:
          if (start) begin
            state <= (cfg.fil_size == `LWIDTH'(1)) ? S_ACTIVE : S_CHARGE;
          end
        S_CHARGE:
          if (line_end && y_cnt == cfg.fil_size - `LWIDTH'(2)) begin
            state <= S_ACTIVE;
          end
        S_ACTIVE:
          if (line_end && y_cnt == cfg.img_size - 1'b1) begin
            state <= S_WAIT;
          end
        default:
          state <= S_WAIT;
      endcase
    end
  end

  // column, line and write-select counters for the incoming pixel.
  always_ff @(posedge clk) begin
    if (!xrst || !pix_req) begin
      x_cnt  <= '0;
      y_cnt  <= '0;
      ws_cnt <= '0;
    end else if (line_end) begin
      x_cnt  <= '0;
      y_cnt  <= y_cnt + 1'b1;
      ws_cnt <= (ws_cnt == SEL_BITS'(`MAXLINE)) ? '0 : ws_cnt + 1'b1;
    end else begin
      x_cnt <= x_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      a_v <= 1'b0;
      b_v <= 1'b0;
    end else begin
      a_v <= pix_req;
      b_v <= a_v;
    end
  end

  always_ff @(posedge clk) begin
    a_pix <= pix_in;
    a_x   <= x_cnt;
    a_y   <= y_cnt;
    a_ws  <= ws_cnt;
    b_pix <= a_pix;  // lines up with the RAM read data.
    b_x   <= a_x;
    b_y   <= a_y;
    b_ws  <= a_ws;
  end

  assign ram_addr = a_x[ADDR_BITS-1:0];

  always_comb begin
    for (int k = 0; k < NRAM; k++) begin
      ram_we[k] = a_v && (a_ws == SEL_BITS'(k));
    end
  end

  for (genvar k = 0; k < NRAM; k++) begin : g_ram
    mem_sp #(
      .DEPTH_BITS(ADDR_BITS)
    ) u_mem (
      .clk  (clk),
      .we   (ram_we[k]),
      .addr (ram_addr),
      .wdata(a_pix),
      .rdata(ram_rd[k])
    );
  end

  // window row r takes image line y - fil_size + 1 + r, which sits in the RAM
  // written fil_size - 1 - r lines before the current one.
  always_comb begin
    int sel;
    for (int r = 0; r < `MAXLINE; r++) begin
      sel = int'(b_ws) - (int'(cfg.fil_size) - 1 - r);
      if (sel < 0) begin
        sel = sel + NRAM;
      end
      if (r + 1 >= int'(cfg.fil_size)) begin
        col_pix[r] = b_pix;
      end else begin
        col_pix[r] = ram_rd[sel];
      end
    end
  end

  for (genvar i = 0; i < `MAXLINE*`MAXLINE; i++) begin : g_win
    localparam int COL = i % `MAXLINE;
    localparam int ROW = i / `MAXLINE;

    if (COL == `MAXLINE - 1) begin : g_edge
      always_ff @(posedge clk) begin
        if (b_v) begin
          win_q[i] <= col_pix[ROW];
        end
      end
    end else begin : g_shift
      always_ff @(posedge clk) begin
        if (b_v) begin
          if (COL == cfg.fil_size - 1'b1) begin
            win_q[i] <= col_pix[ROW];  // newest column enters at fil_size - 1.
          end else begin
            win_q[i] <= win_q[i+1];
          end
        end
      end
    end

    assign win[i] = win_q[i];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= b_v && (b_x >= cfg.fil_size - 1'b1) && (b_y >= cfg.fil_size - 1'b1);
    end
  end

  a_we_onehot: assert property (@(posedge clk) disable iff (!xrst) $onehot0(ram_we));

  a_fil_range: assert property (@(posedge clk) disable iff (!xrst)
    start |-> (cfg.fil_size >= 1) && (cfg.fil_size <= `MAXLINE));

  a_img_range: assert property (@(posedge clk) disable iff (!xrst)
    start |-> (cfg.img_size >= cfg.fil_size) && (cfg.img_size <= `MAXSIZE));

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cnn_pkg.sv
mem_sp.sv
linebuf.sv
conv_core.sv
conv_regs.sv
conv_top.sv
tb_conv_top.sv

//--- mem_sp.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sp
  import cnn_pkg::*;
#(
  parameter int DEPTH_BITS = 5
) (
  input  wire                  clk,
  input  wire                  we,
  input  wire [DEPTH_BITS-1:0] addr,
  input  wire pixel_t          wdata,
  output pixel_t               rdata
);

  pixel_t mem [2**DEPTH_BITS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // old contents come out while the new pixel goes in.
  end

endmodule

`default_nettype wire

//--- tb_conv_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module tb_conv_top
  import cnn_pkg::*;
();

  localparam int     NW          = `MAXLINE * `MAXLINE;
  localparam int     PERIOD      = 100;
  localparam int     TEST_CYCLES = 12*12 + 8*8 + 10*10 + 6*6 + 32*32 + 6*200;
  localparam longint WATCHDOG_NS = 2 * PERIOD * TEST_CYCLES;

  logic      clk;
  logic      xrst;
  axil_req_t axi_req;
  axil_rsp_t axi_rsp;
  pixel_t    pix_in;
  logic      pix_req;
  acc_t      res;
  logic      res_valid;

  logic [31:0]        rng;
  pixel_t             frame [`MAXSIZE*`MAXSIZE];
  int                 w_model [NW];
  logic signed [63:0] exp_q [$];
  int                 res_seen;
  int                 errors;
  int                 err_mark;
  int                 tests_ok;
  int                 tests_bad;

  conv_top UUT (
    .clk      (clk),
    .xrst     (xrst),
    .axi_req  (axi_req),
    .axi_rsp  (axi_rsp),
    .pix_in   (pix_in),
    .pix_req  (pix_req),
    .res      (res),
    .res_valid(res_valid)
  );

  always #(PERIOD/2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("%0t ns: the run took too long and was stopped by the watchdog", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string what, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    @(negedge clk);
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = addr;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = 4'hF;
    axi_req.bready  = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 20) begin
        abort_run("an AXI write got no write response");
      end
    end while (!axi_rsp.bvalid);
    resp            = axi_rsp.bresp;
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b0;
    @(negedge clk);
    axi_req.bready = 1'b0;  // bvalid drops on the edge in between.
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    @(negedge clk);
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = addr;
    axi_req.rready  = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 20) begin
        abort_run("an AXI read got no read data");
      end
    end while (!axi_rsp.rvalid);
    data            = axi_rsp.rdata;
    resp            = axi_rsp.rresp;
    axi_req.arvalid = 1'b0;
    @(negedge clk);
    axi_req.rready = 1'b0;
  endtask

  // every weight gets a fresh random word, of which the low bits are kept signed.
  task automatic set_weights();
    logic [31:0] v;
    logic [1:0]  resp;
    for (int i = 0; i < NW; i++) begin
      v = next_rand();
      write_reg(8'(`REG_WBASE + 4*i), v, resp);
      check_value("weight write response", resp, 0);
      w_model[i] = $signed(v[`WWIDTH-1:0]);
    end
  endtask

  // fills the frame and queues the expected results in raster order.
  task automatic load_frame(input int img, input int fil);
    logic signed [63:0] acc;
    for (int i = 0; i < img*img; i++) begin
      frame[i] = pixel_t'(next_rand());
    end
    exp_q.delete();
    for (int y = fil - 1; y < img; y++) begin
      for (int x = fil - 1; x < img; x++) begin
        acc = 0;
        for (int r = 0; r < fil; r++) begin
          for (int c = 0; c < fil; c++) begin
            acc = acc + frame[(y - fil + 1 + r)*img + (x - fil + 1 + c)]
                        * w_model[r*`MAXLINE + c];
          end
        end
        exp_q.push_back(acc);
      end
    end
  endtask

  task automatic feed_pixels(input int total);
    int idx;
    int idle;
    idx  = 0;
    idle = 0;
    while (idx < total) begin
      @(negedge clk);
      if (pix_req) begin
        pix_in = frame[idx];
        idx++;
      end else begin
        idle++;
        if (idle > 50) begin
          abort_run("the engine stopped asking for pixels before the frame was complete");
        end
      end
    end
    @(negedge clk);
    check_value("pixel request after the last pixel", pix_req, 0);
  endtask

  task automatic run_frame(input int img, input int fil, input bit probe);
    logic [31:0] data;
    logic [1:0]  resp;
    int          total;
    int          waited;
    write_reg(`REG_IMG, img, resp);
    write_reg(`REG_FIL, fil, resp);
    set_weights();
    load_frame(img, fil);
    total    = (img - fil + 1) * (img - fil + 1);
    res_seen = 0;
    fork
      feed_pixels(img*img);
      begin
        write_reg(`REG_CTRL, 32'd1, resp);
        if (probe) begin
          read_reg(`REG_STAT, data, resp);
          check_value("status during frame", data[1:0], 1);
          write_reg(`REG_CTRL, 32'd1, resp);  // lands while busy.
        end
      end
    join
    waited = 0;
    while (res_seen < total) begin
      @(negedge clk);
      waited++;
      if (waited > 200) begin
        abort_run("the engine gave fewer results than the frame needs");
      end
    end
    repeat (10) @(negedge clk);
    check_value("result count", res_seen, total);
    read_reg(`REG_STAT, data, resp);
    check_value("status after frame", data, 2);
  endtask

  task automatic check_registers();
    logic [31:0] v;
    logic [31:0] data;
    logic [1:0]  resp;
    v = next_rand();
    write_reg(`REG_IMG, v, resp);
    read_reg(`REG_IMG, data, resp);
    check_value("image size readback", data, v[`LWIDTH-1:0]);
    v = next_rand();
    write_reg(`REG_FIL, v, resp);
    read_reg(`REG_FIL, data, resp);
    check_value("filter size readback", data, v[`LWIDTH-1:0]);
    set_weights();
    for (int i = 0; i < NW; i++) begin
      read_reg(8'(`REG_WBASE + 4*i), data, resp);
      check_value("weight readback", $signed(data), w_model[i]);
      check_value("weight read response", resp, 0);
    end
    write_reg(8'h10, next_rand(), resp);
    check_value("unmapped write response", resp, 2);
    read_reg(8'h10, data, resp);
    check_value("unmapped read response", resp, 2);
    check_value("unmapped read data", data, 0);
    read_reg(8'(`REG_WBASE + 4*NW), data, resp);
    check_value("read past weights response", resp, 2);
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // results are taken on the falling edge where they are stable.
  always @(negedge clk) begin
    logic signed [63:0] want;
    if (xrst && res_valid) begin
      res_seen++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("%0t ns: a result came out that the model did not expect", $time);
      end else begin
        want = exp_q.pop_front();
        check_value("result", res, want);
      end
    end
  end

  initial begin
    clk       = 1'b0;
    xrst      = 1'b0;
    axi_req   = '0;
    pix_in    = '0;
    rng       = 32'ha1a88c98;
    errors    = 0;
    err_mark  = 0;
    tests_ok  = 0;
    tests_bad = 0;
    res_seen  = 0;
    repeat (8) @(negedge clk);
    xrst = 1'b1;

    check_registers();
    end_test("register access");
    run_frame(12, 5, 1'b0);
    end_test("5x5 filter on 12x12 image");
    run_frame(8, 3, 1'b0);
    end_test("3x3 filter on 8x8 image");
    run_frame(10, 3, 1'b1);
    end_test("status bits");
    run_frame(6, 1, 1'b0);
    run_frame(32, 4, 1'b0);
    end_test("consecutive frames");

    $display("tests ok: %0d, tests with errors: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
